// File: source/rv32Pkg.sv
/* Shared RV32I definitions. Instruction bits 1:0 are never stored, so every
   instruction view below covers bits 31 to 2 only. */
package rv32Pkg;

   // Data word and register index widths
   localparam int xlen = 32;
   localparam int regAddrWidth = 5;

   // Opcode field, instruction bits 6 to 2
   typedef enum logic [4:0] {
      load   = 5'b00000,
      aluImm = 5'b00100,
      auipc  = 5'b00101,
      store  = 5'b01000,
      aluReg = 5'b01100,
      lui    = 5'b01101,
      branch = 5'b11000,
      jalr   = 5'b11001,
      jal    = 5'b11011,
      system = 5'b11100
   } opcodeT;

   // One latched word, four ways to read it
   typedef union packed {
      // R view, also used for register indices and funct3
      struct packed {
         logic [6:0]              funct7;
         logic [regAddrWidth-1:0] rs2;
         logic [regAddrWidth-1:0] rs1;
         logic [2:0]              funct3;
         logic [regAddrWidth-1:0] rd;
         logic [4:0]              opcode;
      } r;
      // I view
      struct packed {
         logic [11:0]             imm11_0;
         logic [regAddrWidth-1:0] rs1;
         logic [2:0]              funct3;
         logic [regAddrWidth-1:0] rd;
         logic [4:0]              opcode;
      } i;
      // S view, B immediate is built from the same fields
      struct packed {
         logic [6:0]              imm11_5;
         logic [regAddrWidth-1:0] rs2;
         logic [regAddrWidth-1:0] rs1;
         logic [2:0]              funct3;
         logic [4:0]              imm4_0;
         logic [4:0]              opcode;
      } s;
      // U view, J immediate is a reshuffle of imm31_12
      struct packed {
         logic [19:0]             imm31_12;
         logic [regAddrWidth-1:0] rd;
         logic [4:0]              opcode;
      } u;
   } instrWordT;

   // One-hot state, bit 0 is fetch
   typedef struct packed {
      logic waitAluOrMem;
      logic execute;
      logic waitInstr;
      logic fetchInstr;
   } stateT;

   // Access size in funct3 bits 1:0
   localparam logic [1:0] sizeByte = 2'b00;
   localparam logic [1:0] sizeHalf = 2'b01;
   localparam logic [1:0] sizeWord = 2'b10;

endpackage

// File: source/coreControl.sv
/* One-hot FSM of the core. Reset enters waitAluOrMem so a write still pending
   in the memory finishes before the first fetch. */
module coreControl (
   input  logic           clk,
   input  logic           reset,
   input  logic           isLoad,
   input  logic           isStore,
   input  logic           isAlu,
   input  logic           isBranch,
   input  logic           isShift,
   input  logic           memRbusy,
   input  logic           memWbusy,
   input  logic           aluBusy,
   input  logic [3:0]     storeMask,
   output rv32Pkg::stateT state,
   output logic           fetchPhase,
   output logic           decodeLoad,
   output logic           execPhase,
   output logic           aluStart,
   output logic           regWrite,
   output logic           memRstrb,
   output logic [3:0]     memWmask
);
   import rv32Pkg::*;

   // Encodings of the four states
   localparam stateT stFetch = '{fetchInstr: 1'b1, default: 1'b0};
   localparam stateT stWaitInstr = '{waitInstr: 1'b1, default: 1'b0};
   localparam stateT stExecute = '{execute: 1'b1, default: 1'b0};
   localparam stateT stWaitAluOrMem = '{waitAluOrMem: 1'b1, default: 1'b0};

   logic instrValid;
   logic needToWait;
   logic waitDone;

   // Loads, stores and shifts finish in waitAluOrMem
   assign needToWait = isLoad | isStore | isShift;
   assign waitDone = !aluBusy & !memRbusy & !memWbusy;

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= stWaitAluOrMem;
         instrValid <= 1'b0;
      end else begin
         // Set once the first instruction is latched
         if (decodeLoad)
            instrValid <= 1'b1;
         case (1'b1)
            state.fetchInstr: state <= stWaitInstr;
            state.waitInstr: if (!memRbusy) state <= stExecute;
            state.execute: state <= needToWait ? stWaitAluOrMem : stFetch;
            state.waitAluOrMem: if (waitDone) state <= stFetch;
            // Illegal encoding, recover through the wait state
            default: state <= stWaitAluOrMem;
         endcase
      end
   end

   // PC drives the address bus until the instruction arrives
   assign fetchPhase = state.fetchInstr | state.waitInstr;
   assign decodeLoad = state.waitInstr & !memRbusy;
   assign execPhase = state.execute;
   assign aluStart = state.execute & isAlu;

   // Early write for single-cycle results, late write for loads and shifts
   assign regWrite = state.execute & !needToWait & !isBranch
                   | state.waitAluOrMem & waitDone & instrValid & (isLoad | isShift);

   // Instruction fetch or load data request
   assign memRstrb = state.fetchInstr | state.execute & isLoad;
   assign memWmask = {4{state.execute & isStore}} & storeMask;

endmodule

// File: source/instrDecoder.sv
/* Instruction register and decoder. Bits 1:0 of the fetched word are dropped
   and assumed to be 2'b11. */
module instrDecoder (
   input  logic                                 clk,
   input  logic                                 decodeLoad,
   input  logic [rv32Pkg::xlen-1:0]             memRdata,
   output rv32Pkg::instrWordT                   instr,
   output logic                                 isLoad,
   output logic                                 isAluImm,
   output logic                                 isAluReg,
   output logic                                 isAlu,
   output logic                                 isAuipc,
   output logic                                 isStore,
   output logic                                 isLui,
   output logic                                 isBranch,
   output logic                                 isJalr,
   output logic                                 isJal,
   output logic                                 isShift,
   output logic [7:0]                           funct3Is,
   output logic [rv32Pkg::regAddrWidth-1:0]     rdId,
   output logic [rv32Pkg::xlen-1:0]             iImm,
   output logic [rv32Pkg::xlen-1:0]             sImm,
   output logic [rv32Pkg::xlen-1:0]             bImm,
   output logic [rv32Pkg::xlen-1:0]             uImm,
   output logic [rv32Pkg::xlen-1:0]             jImm
);
   import rv32Pkg::*;

   // Latched in the cycle the fetch data is valid
   always_ff @(posedge clk) begin
      if (decodeLoad)
         instr <= memRdata[xlen-1:2];
   end

   // Opcode classes
   assign isLoad   = instr.r.opcode == load;
   assign isAluImm = instr.r.opcode == aluImm;
   assign isAuipc  = instr.r.opcode == auipc;
   assign isStore  = instr.r.opcode == store;
   assign isAluReg = instr.r.opcode == aluReg;
   assign isLui    = instr.r.opcode == lui;
   assign isBranch = instr.r.opcode == branch;
   assign isJalr   = instr.r.opcode == jalr;
   assign isJal    = instr.r.opcode == jal;
   assign isAlu    = isAluImm | isAluReg;

   // funct3Is[k] is set when funct3 equals k
   assign funct3Is = 8'b0000_0001 << instr.r.funct3;
   // SLL and SRL/SRA, immediate or register form
   assign isShift = isAlu & (funct3Is[1] | funct3Is[5]);
   assign rdId = instr.r.rd;

   // Sign-extended immediates
   assign iImm = {{(xlen-11){instr.i.imm11_0[11]}}, instr.i.imm11_0[10:0]};
   assign sImm = {{(xlen-11){instr.s.imm11_5[6]}}, instr.s.imm11_5[5:0], instr.s.imm4_0};
   // B swaps bit 11 into the low field slot
   assign bImm = {{(xlen-12){instr.s.imm11_5[6]}}, instr.s.imm4_0[0],
                  instr.s.imm11_5[5:0], instr.s.imm4_0[4:1], 1'b0};
   assign uImm = {instr.u.imm31_12, 12'b0};
   assign jImm = {{(xlen-20){instr.u.imm31_12[19]}}, instr.u.imm31_12[7:0],
                  instr.u.imm31_12[8], instr.u.imm31_12[18:9], 1'b0};

endmodule

// File: source/registerFile.sv
/* 32 x 32 register file without reset. x0 reads zero; sources are read
   straight from the fetched word. */
module registerFile (
   input  logic                             clk,
   input  logic                             decodeLoad,
   input  logic [rv32Pkg::xlen-1:0]         memRdata,
   input  logic                             regWrite,
   input  logic [rv32Pkg::regAddrWidth-1:0] rdId,
   input  logic [rv32Pkg::xlen-1:0]         writeBackData,
   output logic [rv32Pkg::xlen-1:0]         rs1,
   output logic [rv32Pkg::xlen-1:0]         rs2
);
   import rv32Pkg::*;

   logic [xlen-1:0] regs [0:31];
   instrWordT fetched;

   // Index fields of the word on the bus, not the latched one
   assign fetched = memRdata[xlen-1:2];

   always_ff @(posedge clk) begin
      // Writes to x0 are dropped
      if (regWrite && rdId != '0)
         regs[rdId] <= writeBackData;
      // Operands captured together with the instruction
      if (decodeLoad) begin
         rs1 <= (fetched.r.rs1 == '0) ? '0 : regs[fetched.r.rs1];
         rs2 <= (fetched.r.rs2 == '0) ? '0 : regs[fetched.r.rs2];
      end
   end

endmodule

// File: source/aluUnit.sv
/* ALU with a bit-serial shifter. A shift by N keeps aluBusy high
   for N cycles after aluStart. */
module aluUnit (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     aluStart,
   input  rv32Pkg::instrWordT       instr,
   input  logic [7:0]               funct3Is,
   input  logic                     isAluReg,
   input  logic                     isBranch,
   input  logic                     isShift,
   input  logic [rv32Pkg::xlen-1:0] rs1,
   input  logic [rv32Pkg::xlen-1:0] rs2,
   input  logic [rv32Pkg::xlen-1:0] iImm,
   output logic [rv32Pkg::xlen-1:0] aluOut,
   output logic [rv32Pkg::xlen-1:0] aluPlus,
   output logic                     aluBusy,
   output logic                     predicate
);
   import rv32Pkg::*;

   localparam int shamtWidth = $clog2(xlen);

   logic [xlen-1:0] aluIn2;
   logic [xlen:0] aluMinus;
   logic lt, ltu, eq, isSub;
   logic [xlen-1:0] shiftReg;
   logic [shamtWidth-1:0] shamt;

   // Second operand is rs2 for register ops and branches
   assign aluIn2 = (isAluReg | isBranch) ? rs2 : iImm;

   // Adder, also the JALR target
   assign aluPlus = rs1 + aluIn2;

   // One 33-bit subtract gives SUB and all three compares
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 1'b1;
   assign ltu = aluMinus[xlen];
   assign lt = (rs1[xlen-1] ^ aluIn2[xlen-1]) ? rs1[xlen-1] : aluMinus[xlen];
   assign eq = aluMinus[xlen-1:0] == '0;

   // funct7 bit 5 only means SUB in register form, ADDI has immediate bits there
   assign isSub = isAluReg & instr.r.funct7[5];

   assign aluOut =
      (funct3Is[0] ? (isSub ? aluMinus[xlen-1:0] : aluPlus) : '0) |
      (funct3Is[2] ? {{(xlen-1){1'b0}}, lt}                 : '0) |
      (funct3Is[3] ? {{(xlen-1){1'b0}}, ltu}                : '0) |
      (funct3Is[4] ? rs1 ^ aluIn2                           : '0) |
      (funct3Is[6] ? rs1 | aluIn2                           : '0) |
      (funct3Is[7] ? rs1 & aluIn2                           : '0) |
      (isShift     ? shiftReg                               : '0);

   // Shift amount counts down to zero
   always_ff @(posedge clk) begin
      if (!reset)
         shamt <= '0;
      else if (aluStart & isShift)
         shamt <= aluIn2[shamtWidth-1:0];
      else if (|shamt)
         shamt <= shamt - 1'b1;
   end

   // One bit per cycle, funct7 bit 5 selects arithmetic right shift
   always_ff @(posedge clk) begin
      if (aluStart & isShift)
         shiftReg <= rs1;
      else if (|shamt)
         shiftReg <= funct3Is[1] ? shiftReg << 1
                                 : {instr.r.funct7[5] & shiftReg[xlen-1], shiftReg[xlen-1:1]};
   end

   assign aluBusy = |shamt;

   // BEQ BNE BLT BGE BLTU BGEU
   assign predicate = funct3Is[0] & eq | funct3Is[1] & !eq
                    | funct3Is[4] & lt | funct3Is[5] & !lt
                    | funct3Is[6] & ltu | funct3Is[7] & !ltu;

endmodule

// File: source/loadStoreUnit.sv
/* Sub-word load and store lane logic. Accesses must not cross a word;
   the low address bits only pick lanes. */
module loadStoreUnit #(
   parameter int addrWidth = 24
) (
   input  logic [rv32Pkg::xlen-1:0] rs1,
   input  logic [rv32Pkg::xlen-1:0] rs2,
   input  logic [rv32Pkg::xlen-1:0] iImm,
   input  logic [rv32Pkg::xlen-1:0] sImm,
   input  logic                     isStore,
   input  logic [7:0]               funct3Is,
   input  logic [rv32Pkg::xlen-1:0] memRdata,
   output logic [addrWidth-1:0]     lsAddr,
   output logic [rv32Pkg::xlen-1:0] memWdata,
   output logic [3:0]               storeMask,
   output logic [rv32Pkg::xlen-1:0] loadData
);
   import rv32Pkg::*;

   logic [xlen-1:0] offset;
   logic byteAccess, halfAccess, wordAccess;
   logic loadSign;
   logic [15:0] loadHalf;
   logic [7:0] loadByte;

   // Stores and loads place the immediate differently
   assign offset = isStore ? sImm : iImm;
   assign lsAddr = rs1[addrWidth-1:0] + offset[addrWidth-1:0];

   // funct3 bit 2 only marks unsigned loads, so both halves decode the size
   assign byteAccess = funct3Is[{1'b0, sizeByte}] | funct3Is[{1'b1, sizeByte}];
   assign halfAccess = funct3Is[{1'b0, sizeHalf}] | funct3Is[{1'b1, sizeHalf}];
   assign wordAccess = funct3Is[{1'b0, sizeWord}];

   // Low byte goes to every lane it may land on, low halfword likewise
   assign memWdata[7:0] = rs2[7:0];
   assign memWdata[15:8] = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign memWdata[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign memWdata[31:24] = lsAddr[0] ? rs2[7:0]
                          : lsAddr[1] ? rs2[15:8] : rs2[31:24];

   // Single lane, either half, or the full word
   assign storeMask = ({4{byteAccess}} & (4'b0001 << lsAddr[1:0]))
                    | ({4{halfAccess}} & (lsAddr[1] ? 4'b1100 : 4'b0011))
                    | {4{wordAccess}};

   // Lane extraction for loads
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // LBU and LHU zero-extend
   assign loadSign = !(funct3Is[4] | funct3Is[5])
                   & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = (byteAccess ? {{(xlen-8){loadSign}}, loadByte}  : '0)
                   | (halfAccess ? {{(xlen-16){loadSign}}, loadHalf} : '0)
                   | (wordAccess ? memRdata                           : '0);

endmodule

// File: source/pcUnit.sv
/* Program counter, addrWidth bits wide. Targets wrap within the address
   space; low PC bits are not checked for alignment. */
module pcUnit #(
   parameter logic [31:0] resetAddr = 32'h0000_0000,
   parameter int addrWidth = 24
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     execPhase,
   input  rv32Pkg::instrWordT       instr,
   input  logic                     isJal,
   input  logic                     isJalr,
   input  logic                     isBranch,
   input  logic                     predicate,
   input  logic [rv32Pkg::xlen-1:0] bImm,
   input  logic [rv32Pkg::xlen-1:0] uImm,
   input  logic [rv32Pkg::xlen-1:0] jImm,
   input  logic [rv32Pkg::xlen-1:0] aluPlus,
   output logic [addrWidth-1:0]     pc,
   output logic [addrWidth-1:0]     pcPlus4,
   output logic [addrWidth-1:0]     pcPlusImm
);

   logic [addrWidth-1:0] pcImm;

   // Opcode bit 3 marks JAL, bit 4 marks AUIPC, otherwise a branch offset
   assign pcImm = instr.r.opcode[1] ? jImm[addrWidth-1:0]
                : instr.r.opcode[2] ? uImm[addrWidth-1:0] : bImm[addrWidth-1:0];

   assign pcPlus4 = pc + addrWidth'(4);
   assign pcPlusImm = pc + pcImm;

   // JALR target has bit 0 cleared
   always_ff @(posedge clk) begin
      if (!reset)
         pc <= resetAddr[addrWidth-1:0];
      else if (execPhase)
         pc <= isJalr                        ? {aluPlus[addrWidth-1:1], 1'b0}
             : (isJal | isBranch & predicate) ? pcPlusImm : pcPlus4;
   end

endmodule

// File: source/riscvCore.sv
/* RV32I core top, no SYSTEM instruction and no misaligned traps.
   memAddr is zero above addrWidth; one instruction is in flight at a time. */
module riscvCore #(
   parameter logic [31:0] resetAddr = 32'h0000_0000,
   parameter int addrWidth = 24
) (
   input  logic                     clk,
   input  logic                     reset,
   output logic [rv32Pkg::xlen-1:0] memAddr,
   output logic [rv32Pkg::xlen-1:0] memWdata,
   output logic [3:0]               memWmask,
   input  logic [rv32Pkg::xlen-1:0] memRdata,
   output logic                     memRstrb,
   input  logic                     memRbusy,
   input  logic                     memWbusy
);
   import rv32Pkg::*;

   // Control and phase signals
   stateT state;
   logic fetchPhase, decodeLoad, execPhase, aluStart, regWrite;

   // Decoded instruction
   instrWordT instr;
   logic isLoad, isAluImm, isAluReg, isAlu, isAuipc, isStore;
   logic isLui, isBranch, isJalr, isJal, isShift;
   logic [7:0] funct3Is;
   logic [regAddrWidth-1:0] rdId;
   logic [xlen-1:0] iImm, sImm, bImm, uImm, jImm;

   // Datapath values
   logic [xlen-1:0] rs1, rs2, aluOut, aluPlus, loadData, writeBackData;
   logic aluBusy, predicate;
   logic [addrWidth-1:0] lsAddr, pc, pcPlus4, pcPlusImm;
   logic [3:0] storeMask;

   coreControl control (.*);

   instrDecoder decoder (.*);

   registerFile regs (.*);

   aluUnit alu (.*);

   loadStoreUnit #(.addrWidth(addrWidth)) lsu (.*);

   pcUnit #(.resetAddr(resetAddr), .addrWidth(addrWidth)) pcu (.*);

   // Instruction fetch uses the PC, everything else the load/store adder
   assign memAddr = xlen'(fetchPhase ? pc : lsAddr);

   // Write-back source, at most one class flag is set
   assign writeBackData =
      (isLui              ? uImm             : '0) |
      (isAluReg | isAluImm ? aluOut          : '0) |
      (isAuipc            ? xlen'(pcPlusImm) : '0) |
      (isJal | isJalr     ? xlen'(pcPlus4)   : '0) |
      (isLoad             ? loadData         : '0);

endmodule

// File: test/core_assertions.sv
/* Bus protocol and store lane checks, bound into every riscvCore instance.
   failCount holds the number of failed checks for the testbench. */
module coreAssertions #(
   parameter logic [31:0] resetAddr = 32'h0000_0000
) (
   input logic                     clk,
   input logic                     reset,
   input logic [rv32Pkg::xlen-1:0] memAddr,
   input logic [rv32Pkg::xlen-1:0] memWdata,
   input logic [3:0]               memWmask,
   input logic                     memRstrb,
   input logic                     memRbusy,
   input logic                     memWbusy,
   input logic [rv32Pkg::xlen-1:0] rs2,
   input rv32Pkg::stateT           state
);
   import rv32Pkg::*;

   int failCount = 0;
   logic seenFetch;
   logic [xlen-1:0] laneBits;
   logic [xlen-1:0] expectData;

   // Set by the first instruction fetch after reset
   always_ff @(posedge clk) begin
      if (!reset)
         seenFetch <= 1'b0;
      else if (memRstrb)
         seenFetch <= 1'b1;
   end

   // rs2 moved up to the lane the low address bits select
   assign expectData = rs2 << {memAddr[1:0], 3'b000};
   assign laneBits = {{8{memWmask[3]}}, {8{memWmask[2]}}, {8{memWmask[1]}}, {8{memWmask[0]}}};

   // Quiet bus until the first fetch
   assert property (@(posedge clk) disable iff (!reset)
      !seenFetch |-> memWmask == '0 && (!memRstrb || state.fetchInstr))
      else begin
         $error("bus access before the first instruction fetch");
         failCount++;
      end

   assert property (@(posedge clk) disable iff (!reset)
      !seenFetch && memRstrb |-> memAddr == resetAddr)
      else begin
         $error("FAILED time %0t memAddr expected %h actual %h", $time, resetAddr,
                $sampled(memAddr));
         failCount++;
      end

   // Read and write requests never share a cycle
   assert property (@(posedge clk) disable iff (!reset)
      !(memRstrb && memWmask != '0))
      else begin
         $error("read strobe and write mask raised in the same cycle");
         failCount++;
      end

   // Busy memory sees a frozen request
   assert property (@(posedge clk) disable iff (!reset)
      memRbusy || memWbusy |=> $stable(memAddr) && $stable(memWmask) && $stable(memRstrb))
      else begin
         $error("bus request changed while the memory was busy");
         failCount++;
      end

   // Byte, either halfword or full word
   assert property (@(posedge clk) disable iff (!reset)
      memWmask != '0 |-> memWmask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                          4'b0011, 4'b1100, 4'b1111})
      else begin
         $error("illegal write mask pattern %b", $sampled(memWmask));
         failCount++;
      end

   assert property (@(posedge clk) disable iff (!reset)
      memWmask != '0 |-> ((memWdata ^ expectData) & laneBits) == '0)
      else begin
         $error("FAILED time %0t memWdata expected %h actual %h", $time,
                $sampled(expectData & laneBits), $sampled(memWdata & laneBits));
         failCount++;
      end

endmodule

bind riscvCore coreAssertions #(.resetAddr(resetAddr)) checks (.*);

// File: test/coreTb.sv
/* Runs a hand-encoded RV32I program from a 4 KB memory with random busy delays.
   Results land at resultBase; the program ends with a marker store and a self jump. */
module coreTb;
   import rv32Pkg::*;

   localparam logic [31:0] resetAddr = 32'h0000_0000;
   localparam int addrWidth = 24;
   localparam int memWords = 1024;
   localparam logic [31:0] dataBase = 32'h0000_0800;
   localparam logic [31:0] resultBase = 32'h0000_0900;
   localparam logic [31:0] markerAddr = 32'h0000_08fc;
   localparam logic [31:0] markerWord = 32'h600d_c0de;
   localparam int maxCycles = 20000;

   // Operands held in x1, x2 and x3
   localparam logic [31:0] valA = 32'h8765_4321;
   localparam logic [31:0] valB = 32'h1234_5678;
   localparam logic [31:0] valC = 32'hffff_fff3;

   logic clk, reset;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0] memWmask;
   logic memRstrb, memRbusy, memWbusy;

   logic [31:0] mem [0:memWords-1];
   int readCount, writeCount, lane, cycles, slot;
   int resultErrors, timeoutErrors, assertErrors;
   logic [31:0] emitAddr, branchExp;
   logic [11:0] branchBit;
   logic [31:0] expected [$];
   string names [$];

   riscvCore #(.resetAddr(resetAddr), .addrWidth(addrWidth)) u_dut (.*);

   always #2 clk = ~clk;

   // Memory model, busy from the cycle after each request
   initial begin
      // Busy delays are drawn from this process, seeded here
      void'($urandom(32'h146f_8f5f));
      forever begin
         @(negedge clk);
         memRbusy = readCount > 0;
         memWbusy = writeCount > 0;
         if (readCount > 0)
            readCount--;
         if (writeCount > 0)
            writeCount--;
         if (memRstrb) begin
            memRdata = mem[memAddr[11:2]];
            readCount = $urandom % 4;
         end
         if (memWmask != 4'b0000) begin
            for (lane = 0; lane < 4; lane++)
               if (memWmask[lane])
                  mem[memAddr[11:2]][8*lane +: 8] = memWdata[8*lane +: 8];
            writeCount = $urandom % 4;
         end
      end
   end

   // Background pattern, unique per byte address
   function automatic logic [31:0] fillWord(logic [31:0] addr);
      return {addr[15:0], addr[31:16]} ^ addr ^ 32'ha5a5_3c3c;
   endfunction

   // Instruction formats, bits 1:0 always 2'b11
   function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, aluReg, 2'b11};
   endfunction

   function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, opcodeT op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], store, 2'b11};
   endfunction

   function automatic logic [31:0] bType(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], branch, 2'b11};
   endfunction

   function automatic logic [31:0] uType(logic [19:0] imm, logic [4:0] rd, opcodeT op);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] jType(logic [20:0] off, logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, jal, 2'b11};
   endfunction

   task automatic emit(input logic [31:0] word);
      mem[emitAddr[11:2]] = word;
      emitAddr += 4;
   endtask

   // Upper part rounded up when the low 12 bits read as negative
   task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] upper;
      upper = (value + 32'h800) >> 12;
      emit(uType(upper[19:0], rd, lui));
      emit(iType(value[11:0], rd, 3'b000, rd, aluImm));
   endtask

   // Result slots follow each other from resultBase, x31 points there
   task automatic saveResult(input logic [4:0] rs, input logic [31:0] exp, input string name);
      emit(sType(12'(slot * 4), rs, 5'd31, 3'b010));
      expected.push_back(exp);
      names.push_back(name);
      slot++;
   endtask

   task automatic checkReg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [31:0] exp, input string name);
      emit(rType(f7, rs2, rs1, f3, 5'd4));
      saveResult(5'd4, exp, name);
   endtask

   task automatic checkImm(input logic [11:0] imm, input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [31:0] exp, input string name);
      emit(iType(imm, rs1, f3, 5'd4, aluImm));
      saveResult(5'd4, exp, name);
   endtask

   // Loads relative to x30, which holds dataBase
   task automatic checkLoad(input logic [2:0] f3, input logic [11:0] offset,
                            input logic [31:0] exp, input string name);
      emit(iType(offset, 5'd30, f3, 5'd4, load));
      saveResult(5'd4, exp, name);
   endtask

   // A skipped ADDI leaves its own bit of x7 clear
   task automatic checkBranch(input logic [2:0] f3, input logic [4:0] rsA, input logic [4:0] rsB,
                              input logic [31:0] a, input logic [31:0] b);
      logic taken;
      case (f3)
         3'b000: taken = a == b;
         3'b001: taken = a != b;
         3'b100: taken = $signed(a) < $signed(b);
         3'b101: taken = $signed(a) >= $signed(b);
         3'b110: taken = a < b;
         default: taken = a >= b;
      endcase
      emit(bType(13'd8, rsB, rsA, f3));
      emit(iType(branchBit, 5'd7, 3'b000, 5'd7, aluImm));
      if (!taken)
         branchExp = branchExp | 32'(branchBit);
      branchBit = branchBit << 1;
   endtask

   task automatic clearBranchAcc();
      emit(iType(12'd0, 5'd0, 3'b000, 5'd7, aluImm));
      branchExp = '0;
      branchBit = 12'd1;
   endtask

   task automatic buildProgram();
      int k;
      logic [31:0] word;
      logic [31:0] here;
      logic [7:0] b;
      logic [15:0] h;
      for (k = 0; k < memWords; k++)
         mem[k] = fillWord(32'(k * 4));
      emitAddr = resetAddr;
      slot = 0;
      loadConst(5'd1, valA);
      loadConst(5'd2, valB);
      loadConst(5'd3, valC);
      loadConst(5'd30, dataBase);
      loadConst(5'd31, resultBase);
      emit(iType(12'd31, 5'd0, 3'b000, 5'd5, aluImm));
      // Register forms on mixed signs
      checkReg(7'h00, 3'b000, 5'd1, 5'd2, valA + valB, "add");
      checkReg(7'h20, 3'b000, 5'd1, 5'd2, valA - valB, "sub");
      checkReg(7'h00, 3'b010, 5'd1, 5'd2, 32'($signed(valA) < $signed(valB)), "slt a b");
      checkReg(7'h00, 3'b010, 5'd2, 5'd1, 32'($signed(valB) < $signed(valA)), "slt b a");
      checkReg(7'h00, 3'b011, 5'd1, 5'd2, 32'(valA < valB), "sltu a b");
      checkReg(7'h00, 3'b011, 5'd2, 5'd1, 32'(valB < valA), "sltu b a");
      checkReg(7'h00, 3'b100, 5'd1, 5'd2, valA ^ valB, "xor");
      checkReg(7'h00, 3'b110, 5'd1, 5'd2, valA | valB, "or");
      checkReg(7'h00, 3'b111, 5'd1, 5'd2, valA & valB, "and");
      // Immediates are sign-extended, also for SLTIU
      checkImm(12'hffb, 3'b000, 5'd1, valA + 32'hffff_fffb, "addi");
      checkImm(12'hff4, 3'b010, 5'd3, 32'($signed(valC) < -12), "slti");
      checkImm(12'hfff, 3'b011, 5'd3, 32'(valC < 32'hffff_ffff), "sltiu max");
      checkImm(12'h005, 3'b011, 5'd2, 32'(valB < 32'd5), "sltiu small");
      checkImm(12'hf00, 3'b100, 5'd2, valB ^ 32'hffff_ff00, "xori");
      checkImm(12'h0f0, 3'b110, 5'd3, valC | 32'h0000_00f0, "ori");
      checkImm(12'h7ff, 3'b111, 5'd1, valA & 32'h0000_07ff, "andi");
      // Serial shifts, x5 holds 31
      checkImm(12'h004, 3'b001, 5'd1, valA << 4, "slli 4");
      checkImm(12'h007, 3'b101, 5'd1, valA >> 7, "srli 7");
      checkImm(12'h407, 3'b101, 5'd1, 32'($signed(valA) >>> 7), "srai 7");
      checkImm(12'h400, 3'b101, 5'd1, valA, "srai 0");
      checkReg(7'h00, 3'b001, 5'd2, 5'd5, valB << 31, "sll 31");
      checkReg(7'h00, 3'b101, 5'd1, 5'd5, valA >> 31, "srl 31");
      checkReg(7'h20, 3'b101, 5'd1, 5'd5, 32'($signed(valA) >>> 31), "sra 31");
      // Sub-word loads of valA at every offset
      emit(sType(12'd0, 5'd1, 5'd30, 3'b010));
      for (k = 0; k < 4; k++) begin
         b = valA[8*k +: 8];
         checkLoad(3'b000, 12'(k), {{24{b[7]}}, b}, $sformatf("lb %0d", k));
         checkLoad(3'b100, 12'(k), {24'b0, b}, $sformatf("lbu %0d", k));
      end
      for (k = 0; k < 4; k += 2) begin
         h = valA[8*k +: 16];
         checkLoad(3'b001, 12'(k), {{16{h[15]}}, h}, $sformatf("lh %0d", k));
         checkLoad(3'b101, 12'(k), {16'b0, h}, $sformatf("lhu %0d", k));
      end
      checkLoad(3'b010, 12'd0, valA, "lw");
      // Sub-word stores into prefilled words
      emit(sType(12'd5, 5'd2, 5'd30, 3'b000));
      word = fillWord(dataBase + 4);
      word[15:8] = valB[7:0];
      checkLoad(3'b010, 12'd4, word, "sb lane 1");
      emit(sType(12'd10, 5'd2, 5'd30, 3'b001));
      word = fillWord(dataBase + 8);
      word[31:16] = valB[15:0];
      checkLoad(3'b010, 12'd8, word, "sh upper");
      emit(sType(12'd15, 5'd1, 5'd30, 3'b000));
      word = fillWord(dataBase + 12);
      word[31:24] = valA[7:0];
      checkLoad(3'b010, 12'd12, word, "sb lane 3");
      emit(uType(20'habcde, 5'd4, lui));
      saveResult(5'd4, 32'habcd_e000, "lui");
      here = emitAddr;
      emit(uType(20'h00012, 5'd4, auipc));
      saveResult(5'd4, here + 32'h0001_2000, "auipc");
      // Each kind once taken, once not taken
      clearBranchAcc();
      checkBranch(3'b000, 5'd1, 5'd1, valA, valA);
      checkBranch(3'b000, 5'd1, 5'd2, valA, valB);
      checkBranch(3'b001, 5'd1, 5'd2, valA, valB);
      checkBranch(3'b001, 5'd2, 5'd2, valB, valB);
      checkBranch(3'b100, 5'd1, 5'd2, valA, valB);
      checkBranch(3'b100, 5'd2, 5'd1, valB, valA);
      saveResult(5'd7, branchExp, "beq bne blt");
      clearBranchAcc();
      checkBranch(3'b101, 5'd2, 5'd1, valB, valA);
      checkBranch(3'b101, 5'd3, 5'd2, valC, valB);
      checkBranch(3'b110, 5'd2, 5'd1, valB, valA);
      checkBranch(3'b110, 5'd1, 5'd2, valA, valB);
      checkBranch(3'b111, 5'd1, 5'd2, valA, valB);
      checkBranch(3'b111, 5'd2, 5'd3, valB, valC);
      saveResult(5'd7, branchExp, "bge bltu bgeu");
      // JAL and JALR each skip an instruction that would clear the link
      here = emitAddr;
      emit(jType(21'd8, 5'd9));
      emit(iType(12'd0, 5'd0, 3'b000, 5'd9, aluImm));
      emit(uType(20'd0, 5'd11, auipc));
      emit(iType(12'd12, 5'd11, 3'b000, 5'd12, jalr));
      emit(iType(12'd0, 5'd0, 3'b000, 5'd12, aluImm));
      saveResult(5'd9, here + 4, "jal link");
      saveResult(5'd12, here + 16, "jalr link");
      // End marker, then spin
      loadConst(5'd13, markerWord);
      emit(sType(12'(markerAddr - dataBase), 5'd13, 5'd30, 3'b010));
      emit(jType(21'd0, 5'd0));
   endtask

   task automatic checkResults();
      int i;
      logic [31:0] actual;
      for (i = 0; i < slot; i++) begin
         actual = mem[resultBase[11:2] + i];
         assert (actual === expected[i])
            else begin
               $display("FAILED time %0t mem[%h] %s expected %h actual %h", $time,
                        resultBase + 4 * i, names[i], expected[i], actual);
               resultErrors++;
            end
      end
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      readCount = 0;
      writeCount = 0;
      resultErrors = 0;
      timeoutErrors = 0;
      buildProgram();
      repeat (2) @(negedge clk);
      reset = 1'b1;
      // Run until the marker store lands
      cycles = 0;
      while (mem[markerAddr[11:2]] !== markerWord && cycles < maxCycles) begin
         @(negedge clk);
         cycles++;
      end
      if (mem[markerAddr[11:2]] !== markerWord) begin
         timeoutErrors++;
         $display("Timeout after %0d cycles waiting for the end marker store", cycles);
      end
      checkResults();
      assertErrors = u_dut.checks.failCount;
      $display("Errors: %0d result, %0d assertion, %0d timeout",
               resultErrors, assertErrors, timeoutErrors);
      if (resultErrors + assertErrors + timeoutErrors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: sources.f
source/rv32Pkg.sv
source/coreControl.sv
source/instrDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/loadStoreUnit.sv
source/pcUnit.sv
source/riscvCore.sv
test/core_assertions.sv
test/coreTb.sv
